//--- logic/fir_pkg.sv
`default_nettype none

package fir_pkg;

    // datapath sizes
    localparam int DATA_W     = 16;
    localparam int NUM_TAPS   = 4;
    localparam int FRAC_BITS  = 15;
    localparam int PROD_W     = 32;
    localparam int COEF_IDX_W = 2;
    // adder width with guard bits for the tap count
    localparam int SUM_W      = PROD_W + COEF_IDX_W;

    // register map, each register spans two byte addresses
    localparam logic [3:0] ADDR_STATUS   = 4'd0;
    localparam logic [3:0] ADDR_RESULT   = 4'd2;
    localparam logic [3:0] ADDR_SAMPLE   = 4'd4;
    localparam logic [3:0] ADDR_COEF0    = 4'd6;
    localparam logic [3:0] ADDR_NEW_COEF = 4'd14;

    // AHB-Lite transfer encodings
    localparam logic       HSIZE_BYTE  = 1'b0;
    localparam logic       HSIZE_HALF  = 1'b1;
    localparam logic [1:0] HTRANS_IDLE = 2'b00;

    typedef logic [DATA_W-1:0] tap_sample_t;
    typedef logic [DATA_W-1:0] tap_coef_t;
    typedef logic [PROD_W-1:0] tap_prod_t;

endpackage

`default_nettype wire

//--- logic/fir_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fir_ctrl_if;

    fir_pkg::tap_sample_t            sample_data;
    logic                            data_ready;
    logic                            new_coefficient_set;
    fir_pkg::tap_coef_t              fir_coefficient;
    logic [fir_pkg::COEF_IDX_W-1:0]  coefficient_num;
    logic                            load_active;
    logic                            modwait;
    logic [fir_pkg::DATA_W-1:0]      fir_out;
    logic                            err;

    // bus side register file
    modport regs (
        output sample_data, data_ready, new_coefficient_set, fir_coefficient,
        input  coefficient_num, load_active, modwait, fir_out, err
    );

    // sequencer, also forwards the sample to tap 0
    modport loader (
        output coefficient_num, load_active, modwait,
        input  sample_data, data_ready, new_coefficient_set, fir_coefficient
    );

    modport drain (
        output fir_out, err
    );

endinterface

`default_nettype wire

//--- logic/ahb_lite_slave.sv
`timescale 1ns/100ps
`default_nettype none

module ahb_lite_slave (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        hsel,
    input  logic [3:0]                  haddr,
    input  logic                        hsize,
    input  logic [1:0]                  htrans,
    input  logic                        hwrite,
    input  logic [fir_pkg::DATA_W-1:0]  hwdata,
    output logic [fir_pkg::DATA_W-1:0]  hrdata,
    output logic                        hresp,
    fir_ctrl_if.regs                    ctrl
);

    // address phase, held for the data phase
    logic       valid_q;
    logic [3:0] addr_q;
    logic       size_q;
    logic       write_q;

    fir_pkg::tap_coef_t coef_table [fir_pkg::NUM_TAPS];

    logic [3:0]                      hw_addr;
    logic                            is_coef;
    logic [fir_pkg::COEF_IDX_W-1:0]  coef_sel;
    logic [fir_pkg::DATA_W-1:0]      lane_mask;
    logic [fir_pkg::DATA_W-1:0]      reg_val;
    logic                            wr_en;
    logic                            rd_en;

    function automatic logic [fir_pkg::DATA_W-1:0] merge_lanes(
        input logic [fir_pkg::DATA_W-1:0] old_val,
        input logic [fir_pkg::DATA_W-1:0] new_val,
        input logic [fir_pkg::DATA_W-1:0] mask
    );
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= 1'b0;
            addr_q  <= '0;
            size_q  <= fir_pkg::HSIZE_BYTE;
            write_q <= 1'b0;
        end else begin
            valid_q <= hsel && (htrans != fir_pkg::HTRANS_IDLE);
            addr_q  <= haddr;
            size_q  <= hsize;
            write_q <= hwrite;
        end
    end

    assign hw_addr = {addr_q[3:1], 1'b0};
    assign is_coef = (addr_q >= fir_pkg::ADDR_COEF0) && (addr_q < fir_pkg::ADDR_NEW_COEF);
    // halfwords 3..6 hold coefficients 0..3
    assign coef_sel = addr_q[2:1] + 2'd1;

    // odd address selects the upper byte lane
    assign lane_mask = (size_q == fir_pkg::HSIZE_BYTE) ?
                       {{8{addr_q[0]}}, {8{!addr_q[0]}}} : '1;

    // writes to status/result and byte access to the top address are illegal
    assign hresp = valid_q && ((write_q && (addr_q < fir_pkg::ADDR_SAMPLE)) ||
                   ((size_q == fir_pkg::HSIZE_BYTE) && (hw_addr == fir_pkg::ADDR_NEW_COEF)
                    && addr_q[0]));

    assign wr_en = valid_q && write_q && !hresp;
    assign rd_en = valid_q && !write_q && !hresp;

    always_comb begin
        reg_val = '0;
        case (hw_addr)
            fir_pkg::ADDR_STATUS: begin
                reg_val[0] = ctrl.new_coefficient_set || ctrl.modwait;
                reg_val[8] = ctrl.err;
            end
            fir_pkg::ADDR_RESULT:   reg_val = ctrl.fir_out;
            fir_pkg::ADDR_SAMPLE:   reg_val = ctrl.sample_data;
            fir_pkg::ADDR_NEW_COEF: reg_val = {{(fir_pkg::DATA_W-1){1'b0}},
                                               ctrl.new_coefficient_set};
            default:                reg_val = coef_table[coef_sel];
        endcase
    end

    assign hrdata = rd_en ? (reg_val & lane_mask) : '0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            coef_table               <= '{default: '0};
            ctrl.sample_data         <= '0;
            ctrl.data_ready          <= 1'b0;
            ctrl.new_coefficient_set <= 1'b0;
            ctrl.fir_coefficient     <= '0;
        end else begin
            // sample consumed once the loader starts its shift
            if (ctrl.modwait) begin
                ctrl.data_ready <= 1'b0;
            end
            if (ctrl.load_active) begin
                ctrl.fir_coefficient <= coef_table[ctrl.coefficient_num];
                // last index done
                if (&ctrl.coefficient_num) begin
                    ctrl.new_coefficient_set <= 1'b0;
                end
            end
            if (wr_en) begin
                if (hw_addr == fir_pkg::ADDR_SAMPLE) begin
                    ctrl.sample_data <= merge_lanes(ctrl.sample_data, hwdata, lane_mask);
                    // byte writes only stage part of a sample
                    if (size_q == fir_pkg::HSIZE_HALF) begin
                        ctrl.data_ready <= 1'b1;
                    end
                end else if (hw_addr == fir_pkg::ADDR_NEW_COEF) begin
                    ctrl.new_coefficient_set <= hwdata[0];
                end else if (is_coef) begin
                    coef_table[coef_sel] <= merge_lanes(coef_table[coef_sel], hwdata,
                                                        lane_mask);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/coeff_loader.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_loader (
    input  logic                          clk,
    input  logic                          n_rst,
    fir_ctrl_if.loader                    ctrl,
    output logic [fir_pkg::NUM_TAPS-1:0]  coef_load,
    output fir_pkg::tap_coef_t            coef_value,
    output logic                          shift,
    output fir_pkg::tap_sample_t          shift_sample,
    output logic                          shift_done
);

    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        COMPUTING
    } state_t;

    state_t state;
    state_t next_state;

    logic [fir_pkg::COEF_IDX_W-1:0] idx;
    logic [fir_pkg::COEF_IDX_W-1:0] idx_q;
    logic                           load_q;
    logic                           start_load;
    logic                           start_shift;

    // a pending coefficient set goes before a pending sample
    assign start_load  = (state == IDLE) && ctrl.new_coefficient_set;
    assign start_shift = (state == IDLE) && !ctrl.new_coefficient_set && ctrl.data_ready;

    assign ctrl.load_active     = start_load || (state == LOADING);
    assign ctrl.coefficient_num = idx;
    assign ctrl.modwait         = start_shift || (state == COMPUTING);

    assign shift        = start_shift;
    assign shift_sample = ctrl.sample_data;
    assign coef_value   = ctrl.fir_coefficient;

    // slave answers an index one cycle later, so the strobe trails by one
    assign coef_load = load_q ? ({{(fir_pkg::NUM_TAPS-1){1'b0}}, 1'b1} << idx_q) : '0;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_load) begin
                    next_state = LOADING;
                end else if (start_shift) begin
                    next_state = COMPUTING;
                end
            end
            LOADING: begin
                if (&idx) begin
                    next_state = IDLE;
                end
            end
            COMPUTING: begin
                if (shift_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            idx        <= '0;
            idx_q      <= '0;
            load_q     <= 1'b0;
            shift_done <= 1'b0;
        end else begin
            state      <= next_state;
            // wraps to 0 after the last tap
            idx        <= ctrl.load_active ? idx + 1'b1 : '0;
            idx_q      <= idx;
            load_q     <= ctrl.load_active;
            shift_done <= shift;
        end
    end

endmodule

`default_nettype wire

//--- logic/fir_tap.sv
`timescale 1ns/100ps
`default_nettype none

module fir_tap (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  coef_load,
    input  fir_pkg::tap_coef_t    coef_value,
    input  logic                  shift,
    input  fir_pkg::tap_sample_t  sample_in,
    output fir_pkg::tap_sample_t  sample_out,
    output fir_pkg::tap_prod_t    prod
);

    fir_pkg::tap_coef_t   coef_q;
    fir_pkg::tap_sample_t sample_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            coef_q   <= '0;
            sample_q <= '0;
        end else begin
            if (coef_load) begin
                coef_q <= coef_value;
            end
            // delay line step
            if (shift) begin
                sample_q <= sample_in;
            end
        end
    end

    assign sample_out = sample_q;
    assign prod       = fir_pkg::tap_prod_t'(coef_q) * fir_pkg::tap_prod_t'(sample_q);

endmodule

`default_nettype wire

//--- logic/fir_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module fir_accumulator (
    input  logic                clk,
    input  logic                n_rst,
    input  fir_pkg::tap_prod_t  prod [fir_pkg::NUM_TAPS],
    input  logic                shift_done,
    fir_ctrl_if.drain           ctrl
);

    logic [fir_pkg::SUM_W-1:0]   sum;
    logic [fir_pkg::SUM_W-1:0]   scaled;
    logic                        sat;
    logic [fir_pkg::DATA_W-1:0]  result;

    always_comb begin
        sum = '0;
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            sum = sum + {{fir_pkg::COEF_IDX_W{1'b0}}, prod[k]};
        end
    end

    // drop the fraction bits
    assign scaled = sum >> fir_pkg::FRAC_BITS;

    // anything above the result width clips to full scale
    assign sat    = |scaled[fir_pkg::SUM_W-1:fir_pkg::DATA_W];
    assign result = sat ? '1 : scaled[fir_pkg::DATA_W-1:0];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ctrl.fir_out <= '0;
            ctrl.err     <= 1'b0;
        end else if (shift_done) begin
            ctrl.fir_out <= result;
            ctrl.err     <= sat;
        end
    end

endmodule

`default_nettype wire

//--- logic/fir_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

module fir_filter_top (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        hsel,
    input  logic [3:0]                  haddr,
    input  logic                        hsize,
    input  logic [1:0]                  htrans,
    input  logic                        hwrite,
    input  logic [fir_pkg::DATA_W-1:0]  hwdata,
    output logic [fir_pkg::DATA_W-1:0]  hrdata,
    output logic                        hresp
);

    fir_ctrl_if ctrl ();

    logic [fir_pkg::NUM_TAPS-1:0]  coef_load;
    fir_pkg::tap_coef_t            coef_value;
    logic                          shift;
    fir_pkg::tap_sample_t          shift_sample;
    logic                          shift_done;

    // delay line, last entry is the sample leaving the window
    fir_pkg::tap_sample_t tap_chain [fir_pkg::NUM_TAPS + 1];
    fir_pkg::tap_prod_t   prod [fir_pkg::NUM_TAPS];

    ahb_lite_slave u_slave (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp),
        .ctrl   (ctrl.regs)
    );

    coeff_loader u_loader (
        .clk          (clk),
        .n_rst        (n_rst),
        .ctrl         (ctrl.loader),
        .coef_load    (coef_load),
        .coef_value   (coef_value),
        .shift        (shift),
        .shift_sample (shift_sample),
        .shift_done   (shift_done)
    );

    assign tap_chain[0] = shift_sample;

    for (genvar k = 0; k < fir_pkg::NUM_TAPS; k++) begin : g_tap
        fir_tap u_tap (
            .clk        (clk),
            .n_rst      (n_rst),
            .coef_load  (coef_load[k]),
            .coef_value (coef_value),
            .shift      (shift),
            .sample_in  (tap_chain[k]),
            .sample_out (tap_chain[k + 1]),
            .prod       (prod[k])
        );
    end

    fir_accumulator u_acc (
        .clk        (clk),
        .n_rst      (n_rst),
        .prod       (prod),
        .shift_done (shift_done),
        .ctrl       (ctrl.drain)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/tb_fir_filter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fir_filter;

    localparam int MAX_CYCLES  = 4000;
    localparam int NUM_SAMPLES = 40;

    // one bus transfer as seen in its address phase and its data phase
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [15:0] wdata;
        logic [15:0] exp_rd;
        logic        exp_err;
    } xfer_t;

    logic        clk;
    logic        n_rst;
    logic        hsel;
    logic [3:0]  haddr;
    logic        hsize;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [15:0] hwdata;
    logic [15:0] hrdata;
    logic        hresp;

    xfer_t       ap;
    xfer_t       dp;
    logic [15:0] rd_seen;
    integer      seed;
    int          cycles;

    // reference model state
    logic [15:0] coef_m [4];
    logic [15:0] tap_coef [4];
    logic [15:0] hist [4];
    logic [15:0] sample_m;
    logic [15:0] result_m;
    logic        err_m;

    tb_clock #(.PERIOD(4)) u_clk (.clk(clk));

    fir_filter_top dut (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    // read data in every data phase that expects it
    assert property (@(negedge clk) disable iff (!n_rst)
        (dp.valid && !dp.write && !dp.exp_err) |-> (hrdata == dp.exp_rd))
    else report_mismatch($sformatf("hrdata %h, expected %h", hrdata, dp.exp_rd));

    // error response only in the data phase of an illegal transfer
    assert property (@(negedge clk) disable iff (!n_rst)
        hresp == (dp.valid && dp.exp_err))
    else report_mismatch($sformatf("hresp %b, expected %b", hresp, dp.valid && dp.exp_err));

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // drives one address phase and the data phase of the previous transfer
    task automatic bus_step(input logic act, input logic wr, input logic sz,
                            input logic [3:0] addr, input logic [15:0] wdata,
                            input logic [15:0] exp_rd, input logic exp_err);
        @(posedge clk);
        #1;
        dp     = ap;
        hwdata = ap.wdata;
        hsel   = act;
        htrans = act ? 2'b10 : fir_pkg::HTRANS_IDLE;
        hwrite = wr;
        hsize  = sz;
        haddr  = addr;
        ap     = '{valid: act, write: wr, wdata: wdata, exp_rd: exp_rd, exp_err: exp_err};
        @(negedge clk);
        rd_seen = hrdata;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic sz, input logic [15:0] data,
                             input logic exp_err);
        bus_step(1'b1, 1'b1, sz, addr, data, 16'h0, exp_err);
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic sz, input logic [15:0] exp_rd,
                            input logic exp_err);
        bus_step(1'b1, 1'b0, sz, addr, 16'h0, exp_rd, exp_err);
    endtask

    task automatic bus_idle();
        bus_step(1'b0, 1'b0, fir_pkg::HSIZE_HALF, 4'h0, 16'h0, 16'h0, 1'b0);
    endtask

    function automatic logic [15:0] status_word(input logic busy, input logic err);
        return {7'b0, err, 7'b0, busy};
    endfunction

    // odd address is the upper byte
    function automatic logic [15:0] lane_of(input logic [3:0] addr, input logic [15:0] val);
        return addr[0] ? (val & 16'hFF00) : (val & 16'h00FF);
    endfunction

    function automatic logic [15:0] byte_merge(input logic [3:0] addr,
                                               input logic [15:0] old_val,
                                               input logic [15:0] new_val);
        return lane_of(addr, new_val) | (old_val & ~lane_of(addr, 16'hFFFF));
    endfunction

    // window moves by one, result is the scaled and clipped sum
    task automatic model_shift(input logic [15:0] s);
        longint acc;
        for (int k = fir_pkg::NUM_TAPS - 1; k > 0; k--) begin
            hist[k] = hist[k - 1];
        end
        hist[0] = s;
        acc = 0;
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            acc += longint'(tap_coef[k]) * longint'(hist[k]);
        end
        acc = acc >> fir_pkg::FRAC_BITS;
        err_m    = acc > 64'hFFFF;
        result_m = err_m ? 16'hFFFF : 16'(acc);
    endtask

    // n status reads while busy, then one after it drops
    task automatic expect_busy(input int n, input logic err_before);
        for (int i = 0; i < n; i++) begin
            read_reg(fir_pkg::ADDR_STATUS, fir_pkg::HSIZE_HALF, status_word(1'b1, err_before),
                     1'b0);
        end
        read_reg(fir_pkg::ADDR_STATUS, fir_pkg::HSIZE_HALF, status_word(1'b0, err_m), 1'b0);
    endtask

    task automatic send_sample(input logic [15:0] s, input int n_busy);
        logic err_before;
        err_before = err_m;
        write_reg(fir_pkg::ADDR_SAMPLE, fir_pkg::HSIZE_HALF, s, 1'b0);
        sample_m = s;
        model_shift(s);
        expect_busy(n_busy, err_before);
        read_reg(fir_pkg::ADDR_RESULT, fir_pkg::HSIZE_HALF, result_m, 1'b0);
        read_reg(fir_pkg::ADDR_SAMPLE, fir_pkg::HSIZE_HALF, sample_m, 1'b0);
        bus_idle();
    endtask

    task automatic store_coefs();
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            write_reg(fir_pkg::ADDR_COEF0 + 4'(2 * k), fir_pkg::HSIZE_HALF, coef_m[k], 1'b0);
        end
    endtask

    // flag is busy for four cycles, then reads back as 0
    task automatic load_coefs();
        store_coefs();
        write_reg(fir_pkg::ADDR_NEW_COEF, fir_pkg::HSIZE_HALF, 16'h0001, 1'b0);
        expect_busy(4, err_m);
        read_reg(fir_pkg::ADDR_NEW_COEF, fir_pkg::HSIZE_HALF, 16'h0000, 1'b0);
        bus_idle();
        tap_coef = coef_m;
    endtask

    initial begin
        seed     = 32'haa19;
        cycles   = 0;
        n_rst    = 1'b0;
        hsel     = 1'b0;
        haddr    = 4'h0;
        hsize    = fir_pkg::HSIZE_BYTE;
        htrans   = fir_pkg::HTRANS_IDLE;
        hwrite   = 1'b0;
        hwdata   = 16'h0;
        ap       = '0;
        dp       = '0;
        rd_seen  = 16'h0;
        coef_m   = '{default: 16'h0};
        tap_coef = '{default: 16'h0};
        hist     = '{default: 16'h0};
        sample_m = 16'h0;
        result_m = 16'h0;
        err_m    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;

        // reset values
        read_reg(fir_pkg::ADDR_STATUS, fir_pkg::HSIZE_HALF, 16'h0, 1'b0);
        read_reg(fir_pkg::ADDR_RESULT, fir_pkg::HSIZE_HALF, 16'h0, 1'b0);
        bus_idle();
        assert (rd_seen == 16'h0) else report_mismatch("result is not 0 after reset");

        // halfword and byte lanes
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            coef_m[k] = 16'($random(seed));
        end
        store_coefs();
        write_reg(4'd9, fir_pkg::HSIZE_BYTE, 16'hA55A, 1'b0);
        coef_m[1] = byte_merge(4'd9, coef_m[1], 16'hA55A);
        write_reg(4'd10, fir_pkg::HSIZE_BYTE, 16'h3CC3, 1'b0);
        coef_m[2] = byte_merge(4'd10, coef_m[2], 16'h3CC3);
        write_reg(4'd4, fir_pkg::HSIZE_BYTE, 16'h1234, 1'b0);
        sample_m = byte_merge(4'd4, sample_m, 16'h1234);
        write_reg(4'd5, fir_pkg::HSIZE_BYTE, 16'h5678, 1'b0);
        sample_m = byte_merge(4'd5, sample_m, 16'h5678);
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            read_reg(fir_pkg::ADDR_COEF0 + 4'(2 * k), fir_pkg::HSIZE_HALF, coef_m[k], 1'b0);
        end
        read_reg(4'd7, fir_pkg::HSIZE_BYTE, lane_of(4'd7, coef_m[0]), 1'b0);
        read_reg(4'd8, fir_pkg::HSIZE_BYTE, lane_of(4'd8, coef_m[1]), 1'b0);
        read_reg(fir_pkg::ADDR_SAMPLE, fir_pkg::HSIZE_HALF, sample_m, 1'b0);

        // illegal accesses leave every register alone
        write_reg(4'd2, fir_pkg::HSIZE_HALF, 16'hFFFF, 1'b1);
        write_reg(4'd1, fir_pkg::HSIZE_BYTE, 16'hFFFF, 1'b1);
        write_reg(4'd15, fir_pkg::HSIZE_BYTE, 16'hFFFF, 1'b1);
        read_reg(4'd15, fir_pkg::HSIZE_BYTE, 16'h0, 1'b1);
        read_reg(fir_pkg::ADDR_STATUS, fir_pkg::HSIZE_HALF, 16'h0, 1'b0);
        read_reg(4'd3, fir_pkg::HSIZE_BYTE, 16'h0, 1'b0);
        read_reg(fir_pkg::ADDR_NEW_COEF, fir_pkg::HSIZE_HALF, 16'h0, 1'b0);
        bus_idle();

        // 13-bit coefficients keep the sum in range
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            coef_m[k] = 16'($random(seed)) & 16'h1FFF;
        end
        load_coefs();
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            send_sample(16'($random(seed)), 2);
        end

        // full scale inputs clip
        coef_m = '{default: 16'hFFFF};
        load_coefs();
        send_sample(16'hFFFF, 2);
        read_reg(fir_pkg::ADDR_RESULT, fir_pkg::HSIZE_HALF, result_m, 1'b0);
        bus_idle();
        assert (rd_seen == 16'hFFFF) else report_mismatch("saturated result is not 0xFFFF");
        read_reg(fir_pkg::ADDR_STATUS, fir_pkg::HSIZE_HALF, status_word(1'b0, err_m), 1'b0);
        bus_idle();
        assert (rd_seen[8]) else report_mismatch("err is not set after saturation");
        coef_m = '{default: 16'h0001};
        load_coefs();
        send_sample(16'h0100, 2);
        read_reg(fir_pkg::ADDR_STATUS, fir_pkg::HSIZE_HALF, status_word(1'b0, err_m), 1'b0);
        bus_idle();
        assert (!rd_seen[8]) else report_mismatch("err is still set after an in-range sample");

        // sample waits behind a coefficient load
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            coef_m[k] = 16'($random(seed)) & 16'h1FFF;
        end
        store_coefs();
        write_reg(fir_pkg::ADDR_NEW_COEF, fir_pkg::HSIZE_HALF, 16'h0001, 1'b0);
        tap_coef = coef_m;
        send_sample(16'($random(seed)), 5);

        repeat (2) bus_idle();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/fir_pkg.sv
logic/fir_ctrl_if.sv
logic/ahb_lite_slave.sv
logic/coeff_loader.sv
logic/fir_tap.sv
logic/fir_accumulator.sv
logic/fir_filter_top.sv
tb/tb_clock.sv
tb/tb_fir_filter.sv

//--- run.sh
#!/bin/sh
# build the FIR filter testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_fir_filter -f list.f &&
./obj_dir/Vtb_fir_filter ||
{ echo "simulation failed"; exit 1; }
